/* build.f */
rtl/axi2per_pkg.sv
rtl/axi2per_req_channel.sv
rtl/axi2per_res_channel.sv
rtl/axi2per.sv
testbench/tb_clk_gen.sv
testbench/tb_per_mem.sv
testbench/tb_axi2per.sv

/* testbench/tb_axi2per.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi2per import axi2per_pkg::*; ();

  localparam int N_ROUNDS    = 12;
  // Seven transfers per round
  localparam int N_TRANS     = N_ROUNDS * 7;
  localparam int WATCHDOG_NS = (N_TRANS * 40 + 100) * 20;

  logic      clk_i, rst_ni;
  axi_ar_t   axi_ar;
  axi_aw_t   axi_aw;
  axi_w_t    axi_w;
  axi_r_t    axi_r;
  axi_b_t    axi_b;
  logic      axi_ar_valid, axi_ar_ready, axi_aw_valid, axi_aw_ready;
  logic      axi_w_valid, axi_w_ready, axi_r_valid, axi_r_ready;
  logic      axi_b_valid, axi_b_ready;
  per_req_t  per_req;
  per_resp_t per_resp;
  logic      per_req_valid, per_gnt, per_r_valid;

  integer    seed;
  int        errors;
  bit        started;
  int        outstanding;

  // Reference copy of the peripheral words
  logic [31:0] ref_mem [1024];

  // Expected responses of the transfers in flight
  axi_r_t    exp_r;
  axi_b_t    exp_b;

  // Outputs one cycle back for the hold checks
  logic [$bits(axi_r_t):0]   r_prev;
  logic [$bits(axi_b_t):0]   b_prev;
  logic [$bits(per_req_t):0] req_prev;

  logic      r_hs, b_hs, accept_hs;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  tb_per_mem i_per_mem (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(per_req), .req_valid_i(per_req_valid),
    .gnt_o(per_gnt), .r_valid_o(per_r_valid), .resp_o(per_resp)
  );

  axi2per i_dut (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .axi_ar_i(axi_ar), .axi_ar_valid_i(axi_ar_valid), .axi_ar_ready_o(axi_ar_ready),
    .axi_aw_i(axi_aw), .axi_aw_valid_i(axi_aw_valid), .axi_aw_ready_o(axi_aw_ready),
    .axi_w_i(axi_w), .axi_w_valid_i(axi_w_valid), .axi_w_ready_o(axi_w_ready),
    .axi_r_o(axi_r), .axi_r_valid_o(axi_r_valid), .axi_r_ready_i(axi_r_ready),
    .axi_b_o(axi_b), .axi_b_valid_o(axi_b_valid), .axi_b_ready_i(axi_b_ready),
    .per_req_o(per_req), .per_req_valid_o(per_req_valid), .per_gnt_i(per_gnt),
    .per_r_valid_i(per_r_valid), .per_resp_i(per_resp)
  );

  // **********************************************************************
  // Protocol tracking
  // **********************************************************************

  assign r_hs      = axi_r_valid && axi_r_ready;
  assign b_hs      = axi_b_valid && axi_b_ready;
  assign accept_hs = (axi_ar_valid && axi_ar_ready) || (axi_aw_valid && axi_aw_ready);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(accept_hs) - int'(r_hs || b_hs);
    end
  end

  always_ff @(posedge clk_i) begin
    r_prev   <= {axi_r_valid, axi_r};
    b_prev   <= {axi_b_valid, axi_b};
    req_prev <= {per_req_valid, per_req};
  end

  // **********************************************************************
  // Checks
  // **********************************************************************

  // Response payloads at the handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni) r_hs |-> axi_r == exp_r)
    else begin
      errors++;
      $display("** Error: axi_r_o expected %h got %h", $sampled(exp_r), $sampled(axi_r));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) b_hs |-> axi_b == exp_b)
    else begin
      errors++;
      $display("** Error: axi_b_o expected %h got %h", $sampled(exp_b), $sampled(axi_b));
    end

  // Valid and payload held under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_r_valid && !axi_r_ready |=> {axi_r_valid, axi_r} == r_prev)
    else begin
      errors++;
      $display("** Error: axi_r_o expected %h got %h", $sampled(r_prev),
               $sampled({axi_r_valid, axi_r}));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_b_valid && !axi_b_ready |=> {axi_b_valid, axi_b} == b_prev)
    else begin
      errors++;
      $display("** Error: axi_b_o expected %h got %h", $sampled(b_prev),
               $sampled({axi_b_valid, axi_b}));
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    per_req_valid && !per_gnt |=> {per_req_valid, per_req} == req_prev)
    else begin
      errors++;
      $display("** Error: per_req_o expected %h got %h", $sampled(req_prev),
               $sampled({per_req_valid, per_req}));
    end

  // Accept order and single outstanding transfer
  assert property (@(posedge clk_i) disable iff (!rst_ni) axi_aw_ready |-> !axi_ar_valid)
    else begin
      errors++;
      $display("Write was accepted while a read was waiting");
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) axi_aw_ready == axi_w_ready)
    else begin
      errors++;
      $display("AW and W readies were not raised together");
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_ar_ready || axi_aw_ready |-> outstanding == 0)
    else begin
      errors++;
      $display("A ready was raised while a transfer was still outstanding");
    end

  // Quiet outputs between reset and the first stimulus
  assert property (@(posedge clk_i) rst_ni && !started |-> !(axi_ar_ready || axi_aw_ready
    || axi_w_ready || per_req_valid || axi_r_valid || axi_b_valid))
    else begin
      errors++;
      $display("** Error: ready/valid outputs expected %h got %h", 6'h00,
               $sampled({axi_ar_ready, axi_aw_ready, axi_w_ready, per_req_valid,
                         axi_r_valid, axi_b_valid}));
    end

  // **********************************************************************
  // Stimulus tasks
  // **********************************************************************

  // Expected R from the reference words
  // The error range reads back zero
  task automatic expect_read(input logic [2:0] id, input logic [31:0] addr);
    logic [31:0] word;
    word = addr[15] ? 32'h0 : ref_mem[addr[11:2]];
    exp_r.id             = id;
    exp_r.data.word      = '0;
    exp_r.data.lane[addr[2]] = word;
    exp_r.resp           = addr[15] ? RESP_SLVERR : RESP_OKAY;
    exp_r.last           = 1'b1;
  endtask

  task automatic expect_write(input logic [2:0] id, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
    exp_b.id   = id;
    exp_b.resp = addr[15] ? RESP_SLVERR : RESP_OKAY;
    if (!addr[15]) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          ref_mem[addr[11:2]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endtask

  task automatic drive_read(input logic [2:0] id, input logic [31:0] addr);
    axi_ar.id    = id;
    axi_ar.addr  = addr;
    axi_ar_valid = 1'b1;
  endtask

  task automatic drive_write(input logic [2:0] id, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
    axi_aw.id   = id;
    axi_aw.addr = addr;
    // Unused lane and its strobes carry noise
    axi_w.data.word          = {$random(seed), $random(seed)};
    axi_w.data.lane[addr[2]] = data;
    axi_w.strb               = 8'($random(seed));
    if (addr[2]) begin
      axi_w.strb[7:4] = strb;
    end else begin
      axi_w.strb[3:0] = strb;
    end
    axi_w.last   = 1'b1;
    axi_aw_valid = 1'b1;
    axi_w_valid  = 1'b1;
  endtask

  // Ready seen before the edge means the handshake happens on that edge
  task automatic wait_accept(input bit is_read);
    do @(negedge clk_i); while (!(is_read ? axi_ar_ready : axi_aw_ready));
    @(posedge clk_i);
    #1;
    if (is_read) begin
      axi_ar_valid = 1'b0;
    end else begin
      axi_aw_valid = 1'b0;
      axi_w_valid  = 1'b0;
    end
  endtask

  // Stall the response for 1 to 4 cycles before taking it
  task automatic take_resp(input bit is_read);
    int stall;
    stall = $unsigned($random(seed)) % 4;
    do @(negedge clk_i); while (!(is_read ? axi_r_valid : axi_b_valid));
    @(posedge clk_i);
    repeat (stall) @(posedge clk_i);
    #1;
    if (is_read) axi_r_ready = 1'b1;
    else         axi_b_ready = 1'b1;
    @(posedge clk_i);
    #1;
    axi_r_ready = 1'b0;
    axi_b_ready = 1'b0;
  endtask

  task automatic do_write(input logic [2:0] id, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
    expect_write(id, addr, data, strb);
    drive_write(id, addr, data, strb);
    wait_accept(1'b0);
    take_resp(1'b0);
  endtask

  task automatic do_read(input logic [2:0] id, input logic [31:0] addr);
    expect_read(id, addr);
    drive_read(id, addr);
    wait_accept(1'b1);
    take_resp(1'b1);
  endtask

  // AR and AW+W in the same cycle
  // The read goes first and sees the old word
  task automatic do_both(input logic [2:0] rid, input logic [2:0] wid,
                         input logic [31:0] addr, input logic [31:0] data);
    expect_read(rid, addr);
    expect_write(wid, addr, data, 4'hf);
    drive_read(rid, addr);
    drive_write(wid, addr, data, 4'hf);
    wait_accept(1'b1);
    take_resp(1'b1);
    wait_accept(1'b0);
    take_resp(1'b0);
  endtask

  // **********************************************************************
  // Main sequence
  // **********************************************************************

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [2:0]  id;
    seed         = 7;
    errors       = 0;
    started      = 1'b0;
    axi_ar       = '0;
    axi_aw       = '0;
    axi_w        = '0;
    axi_ar_valid = 1'b0;
    axi_aw_valid = 1'b0;
    axi_w_valid  = 1'b0;
    axi_r_ready  = 1'b0;
    axi_b_ready  = 1'b0;
    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    #1;
    started = 1'b1;
    for (int n = 0; n < N_ROUNDS; n++) begin
      addr = $random(seed) & 32'h0000_0ffc;
      id   = 3'($random(seed));
      data = $random(seed);
      do_write(id, addr, data, 4'hf);
      data = $random(seed);
      strb = 4'($random(seed));
      do_write(id + 3'd1, addr, data, strb);
      do_read(id + 3'd2, addr);
      data = $random(seed);
      do_both(id + 3'd3, id + 3'd4, addr, data);
      // Same word in the error range
      data = $random(seed);
      do_write(id + 3'd5, addr | 32'h8000, data, 4'hf);
      do_read(id + 3'd6, addr | 32'h8000);
    end
    repeat (5) @(posedge clk_i);
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the transfer count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the transfers did not complete", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_per_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_per_mem import axi2per_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  per_req_t  req_i,
  input  logic      req_valid_i,
  output logic      gnt_o,
  output logic      r_valid_o,
  output per_resp_t resp_o
);

  // 1024 words, word index from addr[11:2]
  logic [PER_DATA_WIDTH-1:0] mem [1024];

  integer   seed;
  int       delay;
  per_req_t req;

  initial begin
    seed      = 7;
    gnt_o     = 1'b0;
    r_valid_o = 1'b0;
    resp_o    = '0;
    // Fill depends on every bit of the word index
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i << 16) ^ (i * 3);
    end
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && req_valid_i) begin
        // Grant after 0 to 2 cycles
        delay = $unsigned($random(seed)) % 3;
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        gnt_o = 1'b1;
        req   = req_i;
        @(posedge clk_i);
        #1;
        gnt_o = 1'b0;
        // Bit 15 marks the error range, memory left untouched there
        resp_o.opc   = req.addr[15];
        resp_o.rdata = '0;
        if (!req.addr[15]) begin
          if (req.wen) begin
            resp_o.rdata = mem[req.addr[11:2]];
          end else begin
            for (int b = 0; b < PER_BE_WIDTH; b++) begin
              if (req.be[b]) begin
                mem[req.addr[11:2]][8*b +: 8] = req.wdata[8*b +: 8];
              end
            end
          end
        end
        // Response pulse in the cycle after the grant
        r_valid_o = 1'b1;
        @(posedge clk_i);
        #1;
        r_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Half of the 20 ns clock period
  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset low for 5 cycles, released just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/axi2per.sv */
`timescale 1ns/1ps
`default_nettype none

module axi2per import axi2per_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // **********************************************************************
  // AXI4 slave port
  // **********************************************************************

  // Read address
  input  axi_ar_t   axi_ar_i,
  input  logic      axi_ar_valid_i,
  output logic      axi_ar_ready_o,

  // Write address
  input  axi_aw_t   axi_aw_i,
  input  logic      axi_aw_valid_i,
  output logic      axi_aw_ready_o,

  // Write data
  input  axi_w_t    axi_w_i,
  input  logic      axi_w_valid_i,
  output logic      axi_w_ready_o,

  // Read data
  output axi_r_t    axi_r_o,
  output logic      axi_r_valid_o,
  input  logic      axi_r_ready_i,

  // Write response
  output axi_b_t    axi_b_o,
  output logic      axi_b_valid_o,
  input  logic      axi_b_ready_i,

  // **********************************************************************
  // Peripheral master port
  // **********************************************************************

  output per_req_t  per_req_o,
  output logic      per_req_valid_o,
  input  logic      per_gnt_i,
  input  logic      per_r_valid_i,
  input  per_resp_t per_resp_i
);

  // Accept pulse and context towards the response side
  logic   trans_req;
  trans_t trans;

  // Handshake done, frees the request side
  logic   trans_done;

  // Request path, AXI to peripheral
  axi2per_req_channel i_req_channel (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .ar_i            ( axi_ar_i        ),
    .ar_valid_i      ( axi_ar_valid_i  ),
    .ar_ready_o      ( axi_ar_ready_o  ),
    .aw_i            ( axi_aw_i        ),
    .aw_valid_i      ( axi_aw_valid_i  ),
    .aw_ready_o      ( axi_aw_ready_o  ),
    .w_i             ( axi_w_i         ),
    .w_valid_i       ( axi_w_valid_i   ),
    .w_ready_o       ( axi_w_ready_o   ),
    .per_req_o       ( per_req_o       ),
    .per_req_valid_o ( per_req_valid_o ),
    .per_gnt_i       ( per_gnt_i       ),
    .trans_req_o     ( trans_req       ),
    .trans_o         ( trans           ),
    .trans_done_i    ( trans_done      )
  );

  // Response path, peripheral back to R or B
  axi2per_res_channel i_res_channel (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .trans_req_i   ( trans_req     ),
    .trans_i       ( trans         ),
    .per_r_valid_i ( per_r_valid_i ),
    .per_resp_i    ( per_resp_i    ),
    .r_o           ( axi_r_o       ),
    .r_valid_o     ( axi_r_valid_o ),
    .r_ready_i     ( axi_r_ready_i ),
    .b_o           ( axi_b_o       ),
    .b_valid_o     ( axi_b_valid_o ),
    .b_ready_i     ( axi_b_ready_i ),
    .trans_done_o  ( trans_done    )
  );

endmodule

`default_nettype wire

/* rtl/axi2per_res_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module axi2per_res_channel import axi2per_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // **********************************************************************
  // Link from the request channel
  // **********************************************************************

  input  logic      trans_req_i,
  input  trans_t    trans_i,

  // Peripheral response
  input  logic      per_r_valid_i,
  input  per_resp_t per_resp_i,

  // **********************************************************************
  // AXI slave responses
  // **********************************************************************

  // Read data
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,

  // Write response
  output axi_b_t    b_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,

  // R or B handshake done
  output logic      trans_done_o
);

  typedef enum logic {
    Idle,
    Pending
  } state_e;

  state_e    state_d, state_q;

  // Context of the transfer in flight
  trans_t    trans_q;

  // Captured peripheral response
  logic [PER_DATA_WIDTH-1:0] rdata_q;
  logic                      opc_q;

  logic       r_hs;
  logic       b_hs;
  logic [1:0] resp;
  axi_data_u  r_data;

  // **********************************************************************
  // Response outputs
  // **********************************************************************

  // Direction recorded at accept picks R or B
  assign r_valid_o = (state_q == Pending) &&  trans_q.read;
  assign b_valid_o = (state_q == Pending) && !trans_q.read;

  assign r_hs         = r_valid_o && r_ready_i;
  assign b_hs         = b_valid_o && b_ready_i;
  assign trans_done_o = r_hs | b_hs;

  // Peripheral error becomes SLVERR
  assign resp = opc_q ? RESP_SLVERR : RESP_OKAY;

  // Place the 32-bit word in its lane, other lane stays zero
  always_comb begin
    r_data = '0;
    r_data.lane[trans_q.lane] = rdata_q;
  end

  // Payload comes from registers, stable while valid waits for ready
  assign r_o.id   = trans_q.id;
  assign r_o.data = r_data;
  assign r_o.resp = resp;
  assign r_o.last = 1'b1;

  assign b_o.id   = trans_q.id;
  assign b_o.resp = resp;

  // **********************************************************************
  // FSM
  // **********************************************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (per_r_valid_i) begin
          state_d = Pending;
        end
      end

      Pending: begin
        if (trans_done_o) begin
          state_d = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Context and data registers
  always_ff @(posedge clk_i) begin
    if (trans_req_i) begin
      trans_q <= trans_i;
    end
    if (per_r_valid_i) begin
      rdata_q <= per_resp_i.rdata;
      opc_q   <= per_resp_i.opc;
    end
  end

endmodule

`default_nettype wire

/* rtl/axi2per_req_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module axi2per_req_channel import axi2per_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // **********************************************************************
  // AXI slave side
  // **********************************************************************

  // Read address
  input  axi_ar_t  ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,

  // Write address
  input  axi_aw_t  aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,

  // Write data
  input  axi_w_t   w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,

  // **********************************************************************
  // Peripheral master side
  // **********************************************************************

  output per_req_t per_req_o,
  output logic     per_req_valid_o,
  input  logic     per_gnt_i,

  // **********************************************************************
  // Link to the response channel
  // **********************************************************************

  output logic     trans_req_o,
  output trans_t   trans_o,
  input  logic     trans_done_i
);

  // Idle waits for AXI, Request holds the bus request, WaitResp waits for R/B
  typedef enum logic [1:0] {
    Idle,
    Request,
    WaitResp
  } state_e;

  state_e   state_d, state_q;

  // Registered peripheral request
  per_req_t req_d, req_q;

  // Accept qualifiers, reads win over writes
  logic     accept_rd;
  logic     accept_wr;

  // Lane of the write, addr bit 2
  logic     wr_lane;

  // Write strobe split per 32-bit lane
  logic [1:0][PER_BE_WIDTH-1:0] strb_lanes;

  // **********************************************************************
  // Accept logic
  // **********************************************************************

  assign accept_rd = (state_q == Idle) && ar_valid_i;

  // Address and data of a write are taken together
  assign accept_wr = (state_q == Idle) && !ar_valid_i && aw_valid_i && w_valid_i;

  assign ar_ready_o = accept_rd;
  assign aw_ready_o = accept_wr;
  assign w_ready_o  = accept_wr;

  assign wr_lane    = aw_i.addr[2];
  assign strb_lanes = w_i.strb;

  // Context goes out in the accept cycle only
  assign trans_req_o  = accept_rd | accept_wr;
  assign trans_o.read = ar_valid_i;
  assign trans_o.id   = ar_valid_i ? ar_i.id : aw_i.id;
  assign trans_o.lane = ar_valid_i ? ar_i.addr[2] : wr_lane;

  // **********************************************************************
  // Peripheral request build
  // **********************************************************************

  always_comb begin
    req_d = req_q;
    if (accept_rd) begin
      // Reads fetch the full 32-bit word
      req_d.addr  = ar_i.addr[PER_ADDR_WIDTH-1:0];
      req_d.wen   = 1'b1;
      req_d.be    = '1;
      req_d.wdata = '0;
    end else if (accept_wr) begin
      // Writes keep only the lane picked by addr[2]
      req_d.addr  = aw_i.addr[PER_ADDR_WIDTH-1:0];
      req_d.wen   = 1'b0;
      req_d.be    = strb_lanes[wr_lane];
      req_d.wdata = w_i.data.lane[wr_lane];
    end
  end

  assign per_req_o       = req_q;
  assign per_req_valid_o = (state_q == Request);

  // **********************************************************************
  // FSM
  // **********************************************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (accept_rd || accept_wr) begin
          state_d = Request;
        end
      end

      Request: begin
        // Request stays up and stable until the grant
        if (per_gnt_i) begin
          state_d = WaitResp;
        end
      end

      WaitResp: begin
        // Busy until the R or B handshake
        if (trans_done_i) begin
          state_d = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

endmodule

`default_nettype wire

/* rtl/axi2per_pkg.sv */
`default_nettype none

package axi2per_pkg;

  // **********************************************************************
  // Widths
  // **********************************************************************

  // AXI slave port
  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned AXI_ID_WIDTH   = 3;
  localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // Peripheral bus, one 32-bit lane of the AXI word
  localparam int unsigned PER_ADDR_WIDTH = 32;
  localparam int unsigned PER_DATA_WIDTH = 32;
  localparam int unsigned PER_BE_WIDTH   = PER_DATA_WIDTH / 8;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // **********************************************************************
  // Channel types
  // **********************************************************************

  // 64-bit data word, either flat or split in two lanes picked by addr[2]
  typedef union packed {
    logic [AXI_DATA_WIDTH-1:0]      word;
    logic [1:0][PER_DATA_WIDTH-1:0] lane;
  } axi_data_u;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    axi_data_u                 data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0] id;
    axi_data_u               data;
    logic [1:0]              resp;
    logic                    last;
  } axi_r_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0] id;
    logic [1:0]              resp;
  } axi_b_t;

  // Peripheral request, wen high means read
  typedef struct packed {
    logic [PER_ADDR_WIDTH-1:0] addr;
    logic                      wen;
    logic [PER_BE_WIDTH-1:0]   be;
    logic [PER_DATA_WIDTH-1:0] wdata;
  } per_req_t;

  // Peripheral response, opc high flags an error
  typedef struct packed {
    logic                      opc;
    logic [PER_DATA_WIDTH-1:0] rdata;
  } per_resp_t;

  // Context of the accepted transfer, handed to the response side
  typedef struct packed {
    logic                    read;
    logic [AXI_ID_WIDTH-1:0] id;
    logic                    lane;
  } trans_t;

endpackage

`default_nettype wire
